// File: design/scaler_pkg.sv
package scaler_pkg;

  // ************************************************************************
  // widths
  // ************************************************************************
  localparam int PIX_W      = 8;
  localparam int DIM_W      = 12;
  localparam int FRAC_W     = 8;
  localparam int POS_W      = DIM_W + FRAC_W;  // 12.8 position
  localparam int K_W        = 16;              // 8.8 scale factor
  localparam int LINE_DEPTH = 2048;

  typedef logic [PIX_W-1:0] pix_t;
  typedef logic [DIM_W-1:0] dim_t;

  // one accumulator word, summed as raw, split as index plus weight
  typedef union packed {
    logic [POS_W-1:0] raw;
    struct packed {
      dim_t              idx;   // source row or column
      logic [FRAC_W-1:0] frac;  // weight of idx+1
    } f;
  } scale_pos_u;

  typedef struct packed {
    dim_t           s_width;
    dim_t           s_height;
    dim_t           t_width;
    dim_t           t_height;
    logic [K_W-1:0] k_h;
    logic [K_W-1:0] k_v;
  } scale_cfg_t;

  // line buffer write port
  typedef struct packed {
    logic en;
    dim_t addr;
    pix_t data;
  } lb_wr_t;

  // vertically blended stream
  typedef struct packed {
    logic valid;
    pix_t data;
  } vpix_t;

endpackage

// File: design/line_buffer.sv
module line_buffer
  import scaler_pkg::*;
(
  input  logic   sys_clk,
  input  lb_wr_t wr,
  input  dim_t   rd_addr,
  output pix_t   rd_data
);

  localparam int AW = $clog2(LINE_DEPTH);

  pix_t mem [LINE_DEPTH];

  always_ff @(posedge sys_clk)
  begin
    if (wr.en)
      mem[wr.addr[AW-1:0]] <= wr.data;
  end

  // registered read, one cycle after the address
  always_ff @(posedge sys_clk)
  begin
    rd_data <= mem[rd_addr[AW-1:0]];
  end

endmodule

// File: design/line_fetch.sv
module line_fetch
  import scaler_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       frame_flag,
  input  scale_cfg_t cfg,
  input  logic       data_ready,
  input  pix_t       data_in,
  input  dim_t       want_rows,
  output logic       rd_req,
  output lb_wr_t     wr0,
  output lb_wr_t     wr1,
  output logic       rows_ready
);

  dim_t loaded;   // lines fully written this frame
  dim_t rd_cnt;
  dim_t wr_addr;
  dim_t goal;
  logic busy;
  logic wr_en;
  logic wr_last;
  logic start;
  logic rd_last;

  // never more lines than the source has
  assign goal    = (want_rows < cfg.s_height) ? want_rows : cfg.s_height;
  assign start   = !busy && (loaded < goal) && data_ready;
  assign rd_last = rd_req && (rd_cnt == cfg.s_width - dim_t'(1));

  assign rows_ready = !busy && (loaded >= goal);

  // ************************************************************************
  // read request, one run of s_width cycles per line
  // ************************************************************************
  always_ff @(posedge sys_clk)
  begin
    if (!rst_n || frame_flag)
    begin
      rd_req <= 1'b0;
      rd_cnt <= '0;
      busy   <= 1'b0;
    end
    else
    begin
      if (start)
        rd_req <= 1'b1;
      else if (rd_last)
        rd_req <= 1'b0;

      if (rd_last)
        rd_cnt <= '0;
      else if (rd_req)
        rd_cnt <= rd_cnt + dim_t'(1);

      if (start)
        busy <= 1'b1;
      else if (wr_en && wr_last)
        busy <= 1'b0;  // line landed
    end
  end

  // ************************************************************************
  // write side, data_in trails rd_req by one cycle
  // ************************************************************************
  always_ff @(posedge sys_clk)
  begin
    if (!rst_n || frame_flag)
    begin
      wr_en   <= 1'b0;
      wr_last <= 1'b0;
      loaded  <= '0;
    end
    else
    begin
      wr_en   <= rd_req;
      wr_last <= rd_last;
      if (wr_en && wr_last)
        loaded <= loaded + dim_t'(1);
    end
  end

  always_ff @(posedge sys_clk)
  begin
    wr_addr <= rd_cnt;
  end

  // line n goes to buffer n mod 2
  assign wr0.en   = wr_en && !loaded[0];
  assign wr0.addr = wr_addr;
  assign wr0.data = data_in;

  assign wr1.en   = wr_en && loaded[0];
  assign wr1.addr = wr_addr;
  assign wr1.data = data_in;

endmodule

// File: design/pixel_blend.sv
module pixel_blend
  import scaler_pkg::*;
(
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              valid_in,
  input  pix_t              p0,
  input  pix_t              p1,
  input  logic [FRAC_W-1:0] frac,
  output logic              valid_out,
  output pix_t              blend
);

  logic [FRAC_W:0]         w0;      // 256 - frac
  logic [PIX_W+FRAC_W-1:0] m0;
  logic [PIX_W+FRAC_W-1:0] m1;
  logic [PIX_W+FRAC_W-1:0] sum;
  logic                    valid_q;

  assign w0  = {1'b1, {FRAC_W{1'b0}}} - {1'b0, frac};
  assign sum = m0 + m1;  // tops out at 255*256

  // stage 1 multiplies, stage 2 sums and drops the fraction
  always_ff @(posedge sys_clk)
  begin
    m0    <= p0 * w0;
    m1    <= p1 * frac;
    blend <= sum[PIX_W+FRAC_W-1:FRAC_W];
  end

  always_ff @(posedge sys_clk)
  begin
    if (!rst_n)
    begin
      valid_q   <= 1'b0;
      valid_out <= 1'b0;
    end
    else
    begin
      valid_q   <= valid_in;
      valid_out <= valid_q;
    end
  end

endmodule

// File: design/vert_scaler.sv
module vert_scaler
  import scaler_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       frame_flag,
  input  scale_cfg_t cfg,
  input  logic       rows_ready,
  output dim_t       rd_addr,
  input  pix_t       rd0,
  input  pix_t       rd1,
  output dim_t       want_rows,
  output vpix_t      vout,
  output logic       row_start
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETTLE,  // want_rows just moved
    ST_WAIT,
    ST_SWEEP
  } state_t;

  state_t            state;
  scale_pos_u        pos;
  dim_t              col;
  dim_t              row_cnt;
  logic              sweep;
  logic              rd_v1;
  logic              sel1;
  logic              clamp1;
  logic [FRAC_W-1:0] frac1;
  logic              v2;
  logic [FRAC_W-1:0] frac2;
  pix_t              p0_q;
  pix_t              p1_q;
  pix_t              near_pix;
  pix_t              far_pix;
  logic              first1;
  logic              first2;

  assign sweep     = (state == ST_SWEEP);
  assign rd_addr   = col;
  assign want_rows = pos.f.idx + dim_t'(2);  // rows r and r+1

  // ************************************************************************
  // row sweep FSM
  // ************************************************************************
  always_ff @(posedge sys_clk)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      pos.raw <= '0;
      col     <= '0;
      row_cnt <= '0;
    end
    else if (frame_flag)
    begin
      state   <= ST_SETTLE;  // cfg lands this edge
      pos.raw <= '0;
      col     <= '0;
      row_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_SETTLE:
          state <= ST_WAIT;
        ST_WAIT:
          if (rows_ready)
            state <= ST_SWEEP;
        ST_SWEEP:
          if (col == cfg.s_width - dim_t'(1))
          begin
            col <= '0;
            if (row_cnt == cfg.t_height - dim_t'(1))
              state <= ST_IDLE;  // frame done, no extra lines wanted
            else
            begin
              pos.raw <= pos.raw + POS_W'(cfg.k_v);
              row_cnt <= row_cnt + dim_t'(1);
              state   <= ST_SETTLE;
            end
          end
          else
            col <= col + dim_t'(1);
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // ************************************************************************
  // read pipeline and row select
  // ************************************************************************
  always_ff @(posedge sys_clk)
  begin
    sel1   <= pos.f.idx[0];  // row r sits in buffer r mod 2
    clamp1 <= (pos.f.idx + dim_t'(1)) == cfg.s_height;
    frac1  <= pos.f.frac;
  end

  assign near_pix = sel1 ? rd1 : rd0;
  assign far_pix  = sel1 ? rd0 : rd1;

  always_ff @(posedge sys_clk)
  begin
    p0_q  <= near_pix;
    p1_q  <= clamp1 ? near_pix : far_pix;  // last row blends with itself
    frac2 <= frac1;
  end

  always_ff @(posedge sys_clk)
  begin
    if (!rst_n)
    begin
      rd_v1     <= 1'b0;
      v2        <= 1'b0;
      first1    <= 1'b0;
      first2    <= 1'b0;
      row_start <= 1'b0;
    end
    else
    begin
      rd_v1     <= sweep;
      v2        <= rd_v1;
      first1    <= sweep && (col == '0);
      first2    <= first1;
      row_start <= first2;  // one ahead of the first vout
    end
  end

  pixel_blend u_blend (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .valid_in  (v2),
    .p0        (p0_q),
    .p1        (p1_q),
    .frac      (frac2),
    .valid_out (vout.valid),
    .blend     (vout.data)
  );

endmodule

// File: design/horiz_scaler.sv
module horiz_scaler
  import scaler_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       frame_flag,
  input  scale_cfg_t cfg,
  input  vpix_t      vin,
  input  logic       row_start,
  output logic       out_wren,
  output pix_t       data_out
);

  scale_pos_u pos;
  dim_t       x;       // column of the current vin pixel
  dim_t       n_out;   // pixels emitted this row
  pix_t       prev;
  logic       tail_q;  // last column just went by
  logic       room;
  logic       hit;
  logic       tail_hit;
  logic       emit;
  logic       bl_valid;
  pix_t       bl_data;

  assign room = (n_out < cfg.t_width);

  // columns idx and idx+1 both seen
  assign hit = vin.valid && (x == pos.f.idx + dim_t'(1)) && room;

  // final position on the last column, no right neighbour
  assign tail_hit = tail_q && (pos.f.idx == cfg.s_width - dim_t'(1)) && room;

  assign emit = hit || tail_hit;

  // ************************************************************************
  // column tracking and position accumulator
  // ************************************************************************
  always_ff @(posedge sys_clk)
  begin
    if (!rst_n || frame_flag || row_start)
    begin
      pos.raw <= '0;
      x       <= '0;
      n_out   <= '0;
      tail_q  <= 1'b0;
    end
    else
    begin
      tail_q <= vin.valid && (x == cfg.s_width - dim_t'(1));
      if (vin.valid)
        x <= x + dim_t'(1);
      if (emit)
      begin
        pos.raw <= pos.raw + POS_W'(cfg.k_h);
        n_out   <= n_out + dim_t'(1);
      end
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (vin.valid)
      prev <= vin.data;
  end

  pixel_blend u_blend (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .valid_in  (emit),
    .p0        (prev),
    .p1        (tail_hit ? prev : vin.data),
    .frac      (pos.f.frac),
    .valid_out (bl_valid),
    .blend     (bl_data)
  );

  // output register
  always_ff @(posedge sys_clk)
  begin
    if (!rst_n)
      out_wren <= 1'b0;
    else
      out_wren <= bl_valid;
  end

  always_ff @(posedge sys_clk)
  begin
    data_out <= bl_data;
  end

endmodule

// File: design/scaler_top.sv
module scaler_top
  import scaler_pkg::*;
(
  input  logic           sys_clk,
  input  logic           rst_n,
  input  logic           frame_flag,
  input  logic           data_ready,
  output logic           rd_req,
  input  pix_t           data_in,
  input  dim_t           s_width,
  input  dim_t           s_height,
  input  dim_t           t_width,
  input  dim_t           t_height,
  input  logic [K_W-1:0] k_h,
  input  logic [K_W-1:0] k_v,
  output logic           out_wren,
  output pix_t           data_out
);

  scale_cfg_t cfg;
  lb_wr_t     wr0;
  lb_wr_t     wr1;
  dim_t       rd_addr;
  dim_t       want_rows;
  pix_t       rd0;
  pix_t       rd1;
  logic       rows_ready;
  logic       row_start;
  vpix_t      vstream;

  // config held for the whole frame
  always_ff @(posedge sys_clk)
  begin
    if (!rst_n)
      cfg <= '0;
    else if (frame_flag)
      cfg <= '{s_width: s_width, s_height: s_height, t_width: t_width,
               t_height: t_height, k_h: k_h, k_v: k_v};
  end

  line_fetch u_fetch (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .frame_flag (frame_flag),
    .cfg        (cfg),
    .data_ready (data_ready),
    .data_in    (data_in),
    .want_rows  (want_rows),
    .rd_req     (rd_req),
    .wr0        (wr0),
    .wr1        (wr1),
    .rows_ready (rows_ready)
  );

  line_buffer u_buf0 (.sys_clk(sys_clk), .wr(wr0), .rd_addr(rd_addr), .rd_data(rd0));
  line_buffer u_buf1 (.sys_clk(sys_clk), .wr(wr1), .rd_addr(rd_addr), .rd_data(rd1));

  vert_scaler u_vert (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .frame_flag (frame_flag),
    .cfg        (cfg),
    .rows_ready (rows_ready),
    .rd_addr    (rd_addr),
    .rd0        (rd0),
    .rd1        (rd1),
    .want_rows  (want_rows),
    .vout       (vstream),
    .row_start  (row_start)
  );

  horiz_scaler u_horiz (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .frame_flag (frame_flag),
    .cfg        (cfg),
    .vin        (vstream),
    .row_start  (row_start),
    .out_wren   (out_wren),
    .data_out   (data_out)
  );

endmodule

// File: verif/scaler_asserts.sv
module scaler_asserts
  import scaler_pkg::*;
(
  input logic   sys_clk,
  input logic   rst_n,
  input logic   data_ready,
  input logic   rd_req,
  input lb_wr_t wr0,
  input lb_wr_t wr1,
  input dim_t   s_width,
  input logic   out_wren
);

  int fail_cnt = 0;  // assertion failures so far

  // a line run only starts on a sampled data_ready
  rd_req_after_ready: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $rose(rd_req) |-> $past(data_ready))
  else
  begin
    fail_cnt++;
    $error("rd_req rose although data_ready was low the cycle before");
  end

  wr0_addr_in_line: assert property (@(posedge sys_clk) disable iff (!rst_n)
    wr0.en |-> (wr0.addr < s_width))
  else
  begin
    fail_cnt++;
    $error("buffer 0 written past the end of the line");
  end

  wr1_addr_in_line: assert property (@(posedge sys_clk) disable iff (!rst_n)
    wr1.en |-> (wr1.addr < s_width))
  else
  begin
    fail_cnt++;
    $error("buffer 1 written past the end of the line");
  end

  out_quiet_after_reset: assert property (@(posedge sys_clk) $rose(rst_n) |-> !out_wren)
  else
  begin
    fail_cnt++;
    $error("out_wren high in the first cycle after reset");
  end

endmodule

bind scaler_top scaler_asserts u_chk (
  .sys_clk    (sys_clk),
  .rst_n      (rst_n),
  .data_ready (data_ready),
  .rd_req     (rd_req),
  .wr0        (wr0),
  .wr1        (wr1),
  .s_width    (cfg.s_width),
  .out_wren   (out_wren)
);

// File: verif/scaler_tb.sv
module scaler_tb
  import scaler_pkg::*;
();

  localparam int NF       = 8;     // frames in the run
  localparam int FRAME_SZ = 4096;  // room for a 64x64 source

  logic           sys_clk;
  logic           rst_n;
  logic           frame_flag;
  logic           data_ready;
  logic           rd_req;
  pix_t           data_in;
  dim_t           s_width;
  dim_t           s_height;
  dim_t           t_width;
  dim_t           t_height;
  logic [K_W-1:0] k_h;
  logic [K_W-1:0] k_v;
  logic           out_wren;
  pix_t           data_out;

  int          cfg_sw [NF];
  int          cfg_sh [NF];
  int          cfg_tw [NF];
  int          cfg_th [NF];
  int          cfg_kh [NF];
  int          cfg_kv [NF];
  pix_t        src_all [NF*FRAME_SZ];
  pix_t        exp_q [$];
  logic [31:0] rng_state = 32'd96;
  int          frame_no = 0;
  int          exp_lines = 0;
  int          fifo_idx = 0;
  int          lines_started = 0;
  int          run_len = 0;
  int          out_cnt = 0;
  int          chk_cnt = 0;
  int          err_cnt = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  scaler_top u_dut (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .frame_flag (frame_flag),
    .data_ready (data_ready),
    .rd_req     (rd_req),
    .data_in    (data_in),
    .s_width    (s_width),
    .s_height   (s_height),
    .t_width    (t_width),
    .t_height   (t_height),
    .k_h        (k_h),
    .k_v        (k_v),
    .out_wren   (out_wren),
    .data_out   (data_out)
  );

  always #2 sys_clk = ~sys_clk;

  // ************************************************************************
  // helpers
  // ************************************************************************
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> 8;
  endfunction

  // 8.8 factor of at least 1.0 that keeps the last tap inside the source
  function automatic int pick_scale(input int s, input int t);
    int kmax;
    if (t <= 1)
      kmax = 767;
    else
      kmax = (s * 256 - 1) / (t - 1);
    return 256 + int'(next_rand() % (kmax - 255));
  endfunction

  function automatic pix_t blend_px(input int p0, input int p1, input int w);
    return pix_t'((p0 * (256 - w) + p1 * w) >> 8);
  endfunction

  function automatic pix_t src_px(input int f, input int row, input int col);
    return src_all[f * FRAME_SZ + row * cfg_sw[f] + col];
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    chk_cnt++;
    if (got !== want)
    begin
      err_cnt++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  task automatic gen_frames();
    int f;
    int i;
    // 1:1 copy
    cfg_sw[0] = 16;
    cfg_sh[0] = 12;
    cfg_tw[0] = 16;
    cfg_th[0] = 12;
    cfg_kh[0] = 256;
    cfg_kv[0] = 256;
    // last column at 9.375 and last row at 6.5, both on the edge
    cfg_sw[1] = 10;
    cfg_sh[1] = 7;
    cfg_tw[1] = 4;
    cfg_th[1] = 3;
    cfg_kh[1] = 800;
    cfg_kv[1] = 832;
    for (f = 2; f < NF; f++)
    begin
      cfg_sw[f] = 2 + int'(next_rand() % 63);
      cfg_sh[f] = 2 + int'(next_rand() % 63);
      cfg_tw[f] = 1 + int'(next_rand() % cfg_sw[f]);
      cfg_th[f] = 1 + int'(next_rand() % cfg_sh[f]);
      cfg_kh[f] = pick_scale(cfg_sw[f], cfg_tw[f]);
      cfg_kv[f] = pick_scale(cfg_sh[f], cfg_th[f]);
    end
    for (i = 0; i < NF * FRAME_SZ; i++)
      src_all[i] = pix_t'(next_rand());
  endtask

  // ************************************************************************
  // reference model, vertical blend of a row pair then horizontal taps
  // ************************************************************************
  task automatic build_expected(input int f);
    int   j;
    int   i;
    int   c;
    int   c1;
    int   r;
    int   r1;
    int   pos;
    int   fr;
    logic ident;
    pix_t vrow [64];
    ident = (cfg_kh[f] == 256) && (cfg_kv[f] == 256) &&
            (cfg_tw[f] == cfg_sw[f]) && (cfg_th[f] == cfg_sh[f]);
    exp_q.delete();
    for (j = 0; j < cfg_th[f]; j++)
    begin
      pos = j * cfg_kv[f];
      r   = pos >> 8;
      fr  = pos & 255;
      r1  = (r + 1 < cfg_sh[f]) ? r + 1 : r;  // last row pairs with itself
      for (c = 0; c < cfg_sw[f]; c++)
        vrow[c] = blend_px(src_px(f, r, c), src_px(f, r1, c), fr);
      for (i = 0; i < cfg_tw[f]; i++)
      begin
        pos = i * cfg_kh[f];
        c   = pos >> 8;
        fr  = pos & 255;
        c1  = (c + 1 < cfg_sw[f]) ? c + 1 : c;
        if (ident)
          exp_q.push_back(src_px(f, j, i));  // straight copy
        else
          exp_q.push_back(blend_px(vrow[c], vrow[c1], fr));
      end
    end
    // rows r and r+1 of the last output row, never past the source
    pos       = (cfg_th[f] - 1) * cfg_kv[f];
    exp_lines = (pos >> 8) + 2;
    if (exp_lines > cfg_sh[f])
      exp_lines = cfg_sh[f];
  endtask

  // ************************************************************************
  // FIFO model and output monitor
  // ************************************************************************
  always @(posedge sys_clk)
  begin
    if (frame_flag)
    begin
      fifo_idx      = 0;
      lines_started = 0;
      run_len       = 0;
      out_cnt       = 0;
    end
    else if (rd_req)
    begin
      if (run_len == 0)
        lines_started++;
      data_in <= src_all[frame_no * FRAME_SZ + fifo_idx];  // next pixel, one cycle on
      fifo_idx++;
      run_len++;
    end
    else if (run_len != 0)
    begin
      check_val("rd_req run length", run_len, s_width);
      run_len = 0;
    end

    // a full line waits in the FIFO, with random gaps
    data_ready <= (lines_started < s_height) && (next_rand() % 4 != 0);

    if (out_wren)
    begin
      if (exp_q.size() == 0)
      begin
        err_cnt++;
        $display("out_wren pulse with no pixel left to expect in frame %0d", frame_no);
      end
      else
        check_val("data_out", data_out, exp_q.pop_front());
      out_cnt++;
    end
  end

  always @(posedge sys_clk)
  begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit)
    begin
      err_cnt++;
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // ************************************************************************
  // main sequence
  // ************************************************************************
  initial
  begin
    int f;
    int asrt_fails;
    sys_clk    = 1'b0;
    rst_n      = 1'b0;
    frame_flag = 1'b0;
    data_ready = 1'b0;
    data_in    = '0;
    s_width    = '0;
    s_height   = '0;
    t_width    = '0;
    t_height   = '0;
    k_h        = '0;
    k_v        = '0;

    gen_frames();
    for (f = 0; f < NF; f++)
      cycle_limit += 4 * ((cfg_sw[f] + 8) * (cfg_sh[f] + cfg_th[f] + 2) + 64);
    cycle_limit += 100;

    repeat (2) @(posedge sys_clk);
    rst_n <= 1'b1;
    @(posedge sys_clk);

    for (f = 0; f < NF; f++)
    begin
      build_expected(f);
      s_width    <= dim_t'(cfg_sw[f]);
      s_height   <= dim_t'(cfg_sh[f]);
      t_width    <= dim_t'(cfg_tw[f]);
      t_height   <= dim_t'(cfg_th[f]);
      k_h        <= K_W'(cfg_kh[f]);
      k_v        <= K_W'(cfg_kv[f]);
      frame_no   <= f;
      frame_flag <= 1'b1;
      @(posedge sys_clk);
      frame_flag <= 1'b0;

      while (exp_q.size() != 0)
        @(posedge sys_clk);
      repeat (2 * cfg_sw[f] + 16) @(posedge sys_clk);  // stray pulses would land here

      check_val("out_wren count", out_cnt, cfg_tw[f] * cfg_th[f]);
      check_val("lines requested", lines_started, exp_lines);
    end

    asrt_fails = u_dut.u_chk.fail_cnt;
    err_cnt += asrt_fails;
    $display("checks %0d, errors %0d, assertion failures %0d", chk_cnt, err_cnt, asrt_fails);
    if (err_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: sources.f
design/scaler_pkg.sv
design/line_buffer.sv
design/line_fetch.sv
design/pixel_blend.sv
design/vert_scaler.sv
design/horiz_scaler.sv
design/scaler_top.sv
verif/scaler_asserts.sv
verif/scaler_tb.sv

// File: Bender.yml
package:
  name: scaler

sources:
  - design/scaler_pkg.sv
  - design/line_buffer.sv
  - design/line_fetch.sv
  - design/pixel_blend.sv
  - design/vert_scaler.sv
  - design/horiz_scaler.sv
  - design/scaler_top.sv
  - target: simulation
    files:
      - verif/scaler_asserts.sv
      - verif/scaler_tb.sv
